// File: src.f
+incdir+verification
design/rvv_pkg.sv
design/ara_pkg.sv
design/valu.sv
design/vmul.sv
design/vector_fus_stage.sv
design/lane_vrf.sv
design/lane_exec_top.sv
verification/lane_exec_tb.sv

// File: Bender.yml
package:
  name: lane_exec

sources:
  - files:
      - design/rvv_pkg.sv
      - design/ara_pkg.sv
      - design/valu.sv
      - design/vmul.sv
      - design/vector_fus_stage.sv
      - design/lane_vrf.sv
      - design/lane_exec_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/lane_exec_tb.sv

// File: verification/lane_exec_tasks.svh
/*
  Driver, check and reference-model tasks of the lane testbench.
  Included inside the testbench module, so the DUT signals are used directly.
  Inputs change only on the falling clock edge.
*/
`ifndef LANE_EXEC_TASKS_SVH
`define LANE_EXEC_TASKS_SVH

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    errors++;
    $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

// Per element result at the chosen width, wrapped to the element size
task automatic ref_word(input vfu_op_e op, input vew_e vew, input logic [63:0] a,
                        input logic [63:0] b, output logic [63:0] res);
  int unsigned w;
  logic [63:0] mask;
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] r;
  w    = 8 << vew;
  mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  res  = '0;
  for (int i = 0; i < 64 / w; i++) begin
    ea = (a >> (i * w)) & mask;
    eb = (b >> (i * w)) & mask;
    case (op)
      VADD:    r = ea + eb;
      VSUB:    r = ea - eb;
      VAND:    r = ea & eb;
      VOR:     r = ea | eb;
      VXOR:    r = ea ^ eb;
      VMUL:    r = ea * eb;
      default: r = 'x;
    endcase
    res |= (r & mask) << (i * w);
  end
endtask

task automatic issue_op(input vfu_op_e op, input vew_e vew, input int vl, input int vd,
                        input int id);
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (!((op == VMUL) ? mul_ready_o : alu_ready_o) && waited < Timeout) begin
    @(negedge clk_i);
    waited++;
  end
  if (waited >= Timeout) begin
    timeouts++;
    $display("Timeout at %0d ns: unit never became ready to take id %0d", $time, id);
  end
  vfu_operation_i.op    = op;
  vfu_operation_i.vew   = vew;
  vfu_operation_i.vl    = 6'(vl);
  vfu_operation_i.vd    = 5'(vd);
  vfu_operation_i.id    = vid_t'(id);
  vfu_operation_valid_i = 1'b1;
  @(negedge clk_i);
  vfu_operation_valid_i = 1'b0;
endtask

// Ready only moves at the rising edge, so it is stable at the falling edge
task automatic feed_operands(input bit to_mul, input int vl, input int gap_pct);
  int k;
  int stalls;
  logic [1:0] valid;
  logic [1:0] ready;
  k      = 0;
  stalls = 0;
  while (k < vl && stalls < Timeout) begin
    @(negedge clk_i);
    valid[0] = $urandom_range(99) >= gap_pct;
    valid[1] = $urandom_range(99) >= gap_pct;
    if (to_mul) begin
      mul_operand_i[0].e64 = mul_a[k];
      mul_operand_i[1].e64 = mul_b[k];
      mul_operand_valid_i  = valid;
      ready                = mul_operand_ready_o;
    end else begin
      alu_operand_i[0].e64 = alu_a[k];
      alu_operand_i[1].e64 = alu_b[k];
      alu_operand_valid_i  = valid;
      ready                = alu_operand_ready_o;
    end
    // The pair moves at the next rising edge
    if (&valid && &ready) k++;
    else stalls++;
  end
  @(negedge clk_i);
  if (to_mul) mul_operand_valid_i = '0;
  else alu_operand_valid_i = '0;
  if (k < vl) begin
    timeouts++;
    $display("Timeout at %0d ns: only %0d of %0d operand pairs were taken", $time, k, vl);
  end
endtask

task automatic wait_done(input bit to_mul, input int id);
  int waited;
  logic seen;
  waited = 0;
  seen   = 1'b0;
  while (!seen && waited < Timeout) begin
    @(negedge clk_i);
    #1;
    seen = to_mul ? (mul_done_cnt[id] != mul_done_base[id])
                  : (alu_done_cnt[id] != alu_done_base[id]);
    waited++;
  end
  if (!seen) begin
    timeouts++;
    $display("Timeout at %0d ns: no done pulse for id %0d", $time, id);
  end else begin
    // Ready returns in the cycle of the done pulse
    check_value(to_mul ? "mul_ready_o" : "alu_ready_o", to_mul ? mul_ready_o : alu_ready_o, 1'b1);
  end
endtask

task automatic check_register(input int vd);
  for (int w = 0; w < VRegWords; w++) begin
    @(negedge clk_i);
    vrf_raddr_i = AddrWidth'(vd * VRegWords + w);
    #(ClkPeriod / 4);
    check_value($sformatf("vrf_rdata_o v%0d word %0d", vd, w), vrf_rdata_o.e64,
                exp_vrf[vd * VRegWords + w]);
  end
endtask

`endif

// File: verification/lane_exec_tb.sv
`timescale 1ns/1ps
/*
  Directed testbench of the lane execution stage and its register file.
  The testbench plays the sequencer and both operand queues.
  Expected register contents are kept in a shadow copy of the register file.
*/
module lane_exec_tb;
  import ara_pkg::*;
  import rvv_pkg::*;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned Timeout   = 200;
  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned VRegWords = 8;
  localparam int unsigned AddrWidth = $clog2(NrVRegs * VRegWords);

  logic                   clk_i;
  logic                   reset_i;
  vfu_operation_t         vfu_operation_i;
  logic                   vfu_operation_valid_i;
  logic                   alu_ready_o;
  logic [NrVInsn-1:0]     alu_vinsn_done_o;
  logic                   mul_ready_o;
  logic [NrVInsn-1:0]     mul_vinsn_done_o;
  elen_u [1:0]            alu_operand_i;
  logic [1:0]             alu_operand_valid_i;
  logic [1:0]             alu_operand_ready_o;
  elen_u [1:0]            mul_operand_i;
  logic [1:0]             mul_operand_valid_i;
  logic [1:0]             mul_operand_ready_o;
  logic [AddrWidth-1:0]   vrf_raddr_i;
  elen_u                  vrf_rdata_o;

  int          errors;
  int          timeouts;
  logic [63:0] exp_vrf [NrVRegs*VRegWords];
  logic [63:0] alu_a [VRegWords];
  logic [63:0] alu_b [VRegWords];
  logic [63:0] mul_a [VRegWords];
  logic [63:0] mul_b [VRegWords];
  int          alu_done_cnt [NrVInsn];
  int          mul_done_cnt [NrVInsn];
  int          alu_done_base [NrVInsn];
  int          mul_done_base [NrVInsn];

  `include "lane_exec_tasks.svh"

  lane_exec_top #(
    .NrVRegs  (NrVRegs  ),
    .VRegWords(VRegWords)
  ) lane_exec_top_i (
    .clk_i                (clk_i                ),
    .reset_i              (reset_i              ),
    .vfu_operation_i      (vfu_operation_i      ),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .alu_ready_o          (alu_ready_o          ),
    .alu_vinsn_done_o     (alu_vinsn_done_o     ),
    .mul_ready_o          (mul_ready_o          ),
    .mul_vinsn_done_o     (mul_vinsn_done_o     ),
    .alu_operand_i        (alu_operand_i        ),
    .alu_operand_valid_i  (alu_operand_valid_i  ),
    .alu_operand_ready_o  (alu_operand_ready_o  ),
    .mul_operand_i        (mul_operand_i        ),
    .mul_operand_valid_i  (mul_operand_valid_i  ),
    .mul_operand_ready_o  (mul_operand_ready_o  ),
    .vrf_raddr_i          (vrf_raddr_i          ),
    .vrf_rdata_o          (vrf_rdata_o          )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Done bits are registered, the falling edge sees each pulse once
  always @(negedge clk_i) begin
    for (int i = 0; i < NrVInsn; i++) begin
      if (alu_vinsn_done_o[i]) alu_done_cnt[i]++;
      if (mul_vinsn_done_o[i]) mul_done_cnt[i]++;
    end
  end

  task automatic snap_done();
    for (int i = 0; i < NrVInsn; i++) begin
      alu_done_base[i] = alu_done_cnt[i];
      mul_done_base[i] = mul_done_cnt[i];
    end
  endtask

  // An id of -1 means no pulse is expected from that unit
  task automatic check_done_counts(input int alu_id, input int mul_id);
    for (int i = 0; i < NrVInsn; i++) begin
      check_value($sformatf("alu_vinsn_done_o[%0d] pulses", i),
                  alu_done_cnt[i] - alu_done_base[i], (i == alu_id));
      check_value($sformatf("mul_vinsn_done_o[%0d] pulses", i),
                  mul_done_cnt[i] - mul_done_base[i], (i == mul_id));
    end
  endtask

  task automatic make_operands(input bit to_mul, input vfu_op_e op, input vew_e vew,
                               input int vl, input int vd);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    for (int k = 0; k < vl; k++) begin
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      // First word pushes every element across its wrap point
      if (k == 0 && op == VADD) begin
        a = '1;
        b = 64'h0101_0101_0101_0101;
      end
      if (k == 0 && op == VSUB) begin
        a = '0;
        b = 64'h0101_0101_0101_0101;
      end
      ref_word(op, vew, a, b, r);
      exp_vrf[vd * VRegWords + k] = r;
      if (to_mul) begin
        mul_a[k] = a;
        mul_b[k] = b;
      end else begin
        alu_a[k] = a;
        alu_b[k] = b;
      end
    end
  endtask

  task automatic run_single(input vfu_op_e op, input vew_e vew, input int vl, input int vd,
                            input int id, input int gap_pct);
    bit to_mul;
    to_mul = (op == VMUL);
    make_operands(to_mul, op, vew, vl, vd);
    snap_done();
    issue_op(op, vew, vl, vd, id);
    feed_operands(to_mul, vl, gap_pct);
    wait_done(to_mul, id);
    check_register(vd);
    check_done_counts(to_mul ? -1 : id, to_mul ? id : -1);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_value("alu_ready_o", alu_ready_o, 1'b1);
    check_value("mul_ready_o", mul_ready_o, 1'b1);
    check_value("alu_vinsn_done_o", alu_vinsn_done_o, '0);
    check_value("mul_vinsn_done_o", mul_vinsn_done_o, '0);
    check_value("alu_operand_ready_o", alu_operand_ready_o, '0);
    check_value("mul_operand_ready_o", mul_operand_ready_o, '0);
    check_register(0);
    check_register(NrVRegs - 1);
  endtask

  task automatic test_alu_widths();
    for (int w = 0; w < 4; w++) begin
      for (int op = 0; op < 5; op++) begin
        run_single(vfu_op_e'(op), vew_e'(w), $urandom_range(VRegWords, 1), 1 + w * 5 + op,
                   (w * 5 + op) % NrVInsn, 0);
      end
    end
  endtask

  task automatic test_mul_widths();
    for (int w = 0; w < 4; w++) begin
      run_single(VMUL, vew_e'(w), VRegWords, 21 + w, (w + 2) % NrVInsn, 0);
    end
  endtask

  // The ALU keeps the write port, so the multiplier has to wait for gaps
  task automatic test_alu_mul_overlap();
    make_operands(1'b0, VADD, EW16, VRegWords, 25);
    make_operands(1'b1, VMUL, EW8, VRegWords, 26);
    snap_done();
    issue_op(VADD, EW16, VRegWords, 25, 3);
    issue_op(VMUL, EW8, VRegWords, 26, 6);
    fork
      feed_operands(1'b0, VRegWords, 0);
      feed_operands(1'b1, VRegWords, 0);
    join
    wait_done(1'b0, 3);
    wait_done(1'b1, 6);
    check_register(25);
    check_register(26);
    check_done_counts(3, 6);
  endtask

  // Short vl into full registers, the tail words must keep their old data
  task automatic test_backpressure();
    run_single(VSUB, EW32, 5, 21, 4, 40);
    run_single(VMUL, EW64, 3, 22, 7, 50);
    run_single(VXOR, EW8, 6, 25, 1, 60);
  endtask

  initial begin
    errors                = 0;
    timeouts              = 0;
    reset_i               = 1'b1;
    vfu_operation_i       = '0;
    vfu_operation_valid_i = 1'b0;
    alu_operand_i         = '0;
    alu_operand_valid_i   = '0;
    mul_operand_i         = '0;
    mul_operand_valid_i   = '0;
    vrf_raddr_i           = '0;
    for (int i = 0; i < NrVRegs * VRegWords; i++) exp_vrf[i] = '0;
    void'($urandom(32'h2b77_6e37));
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_reset_state();
    test_alu_widths();
    test_mul_widths();
    test_alu_mul_overlap();
    test_backpressure();

    $display("Run finished with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : lane_exec_tb

// File: design/lane_exec_top.sv
`timescale 1ns/1ps
/*
  One lane's execution stage joined to its register file.
  The operand queues and the sequencer sit outside this block.
*/
module lane_exec_top #(
  parameter  int unsigned NrVRegs   = 32,
  parameter  int unsigned VRegWords = 8,
  // Word address into the lane register file
  localparam type         vaddr_t   = logic [$clog2(NrVRegs*VRegWords)-1:0]
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Lane sequencer
  input  ara_pkg::vfu_operation_t         vfu_operation_i,
  input  logic                            vfu_operation_valid_i,
  output logic                            alu_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     alu_vinsn_done_o,
  output logic                            mul_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     mul_vinsn_done_o,
  // Operand queues
  input  rvv_pkg::elen_u [1:0]            alu_operand_i,
  input  logic [1:0]                      alu_operand_valid_i,
  output logic [1:0]                      alu_operand_ready_o,
  input  rvv_pkg::elen_u [1:0]            mul_operand_i,
  input  logic [1:0]                      mul_operand_valid_i,
  output logic [1:0]                      mul_operand_ready_o,
  // Register readback
  input  vaddr_t                          vrf_raddr_i,
  output rvv_pkg::elen_u                  vrf_rdata_o
);

  logic           alu_req;
  vaddr_t         alu_addr;
  rvv_pkg::elen_u alu_wdata;
  logic           alu_gnt;
  logic           mul_req;
  vaddr_t         mul_addr;
  rvv_pkg::elen_u mul_wdata;
  logic           mul_gnt;

  vector_fus_stage #(
    .VRegWords(VRegWords),
    .vaddr_t  (vaddr_t  )
  ) i_vector_fus_stage (
    .clk_i                (clk_i                ),
    .reset_i              (reset_i              ),
    .vfu_operation_i      (vfu_operation_i      ),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .alu_ready_o          (alu_ready_o          ),
    .alu_vinsn_done_o     (alu_vinsn_done_o     ),
    .mul_ready_o          (mul_ready_o          ),
    .mul_vinsn_done_o     (mul_vinsn_done_o     ),
    .alu_operand_i        (alu_operand_i        ),
    .alu_operand_valid_i  (alu_operand_valid_i  ),
    .alu_operand_ready_o  (alu_operand_ready_o  ),
    .mul_operand_i        (mul_operand_i        ),
    .mul_operand_valid_i  (mul_operand_valid_i  ),
    .mul_operand_ready_o  (mul_operand_ready_o  ),
    .alu_result_req_o     (alu_req              ),
    .alu_result_addr_o    (alu_addr             ),
    .alu_result_wdata_o   (alu_wdata            ),
    .alu_result_gnt_i     (alu_gnt              ),
    .mul_result_req_o     (mul_req              ),
    .mul_result_addr_o    (mul_addr             ),
    .mul_result_wdata_o   (mul_wdata            ),
    .mul_result_gnt_i     (mul_gnt              )
  );

  lane_vrf #(
    .NrVRegs  (NrVRegs  ),
    .VRegWords(VRegWords),
    .vaddr_t  (vaddr_t  )
  ) i_lane_vrf (
    .clk_i      (clk_i      ),
    .reset_i    (reset_i    ),
    .alu_wreq_i (alu_req    ),
    .alu_waddr_i(alu_addr   ),
    .alu_wdata_i(alu_wdata  ),
    .alu_wgnt_o (alu_gnt    ),
    .mul_wreq_i (mul_req    ),
    .mul_waddr_i(mul_addr   ),
    .mul_wdata_i(mul_wdata  ),
    .mul_wgnt_o (mul_gnt    ),
    .vrf_raddr_i(vrf_raddr_i),
    .vrf_rdata_o(vrf_rdata_o)
  );

endmodule : lane_exec_top

// File: design/lane_vrf.sv
`timescale 1ns/1ps
/*
  Lane register file, NrVRegs registers of VRegWords 64-bit words.
  Two write ports with the ALU at fixed priority, grants are combinational.
  The read port is combinational.
*/
module lane_vrf #(
  parameter int unsigned NrVRegs   = 32,
  parameter int unsigned VRegWords = 8,
  parameter type         vaddr_t   = logic
) (
  input  logic           clk_i,
  input  logic           reset_i,
  // ALU write port
  input  logic           alu_wreq_i,
  input  vaddr_t         alu_waddr_i,
  input  rvv_pkg::elen_u alu_wdata_i,
  output logic           alu_wgnt_o,
  // Multiplier write port
  input  logic           mul_wreq_i,
  input  vaddr_t         mul_waddr_i,
  input  rvv_pkg::elen_u mul_wdata_i,
  output logic           mul_wgnt_o,
  // Read port
  input  vaddr_t         vrf_raddr_i,
  output rvv_pkg::elen_u vrf_rdata_o
);
  import rvv_pkg::*;

  localparam int unsigned NrWords = NrVRegs * VRegWords;

  elen_u  mem_q [NrWords];
  logic   wen;
  vaddr_t waddr;
  elen_u  wdata;

  // The multiplier waits while the ALU writes
  assign alu_wgnt_o = alu_wreq_i;
  assign mul_wgnt_o = mul_wreq_i && !alu_wreq_i;

  always_comb begin
    wen   = alu_wreq_i || mul_wreq_i;
    waddr = alu_wreq_i ? alu_waddr_i : mul_waddr_i;
    wdata = alu_wreq_i ? alu_wdata_i : mul_wdata_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NrWords; i++) mem_q[i] <= '0;
    end else if (wen) begin
      mem_q[waddr] <= wdata;
    end
  end

  assign vrf_rdata_o = mem_q[vrf_raddr_i];

endmodule : lane_vrf

// File: design/vector_fus_stage.sv
`timescale 1ns/1ps
/*
  Execution stage of one lane, holding the ALU and the multiplier.
  Every operation goes to both units, each keeps only its own ops.
*/
module vector_fus_stage #(
  parameter int unsigned VRegWords = 8,
  parameter type         vaddr_t   = logic
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Lane sequencer
  input  ara_pkg::vfu_operation_t         vfu_operation_i,
  input  logic                            vfu_operation_valid_i,
  output logic                            alu_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     alu_vinsn_done_o,
  output logic                            mul_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     mul_vinsn_done_o,
  // Operand queues
  input  rvv_pkg::elen_u [1:0]            alu_operand_i,
  input  logic [1:0]                      alu_operand_valid_i,
  output logic [1:0]                      alu_operand_ready_o,
  input  rvv_pkg::elen_u [1:0]            mul_operand_i,
  input  logic [1:0]                      mul_operand_valid_i,
  output logic [1:0]                      mul_operand_ready_o,
  // Register file write ports
  output logic                            alu_result_req_o,
  output vaddr_t                          alu_result_addr_o,
  output rvv_pkg::elen_u                  alu_result_wdata_o,
  input  logic                            alu_result_gnt_i,
  output logic                            mul_result_req_o,
  output vaddr_t                          mul_result_addr_o,
  output rvv_pkg::elen_u                  mul_result_wdata_o,
  input  logic                            mul_result_gnt_i
);

  valu #(
    .VRegWords(VRegWords),
    .vaddr_t  (vaddr_t  )
  ) i_valu (
    .clk_i                (clk_i                ),
    .reset_i              (reset_i              ),
    .vfu_operation_i      (vfu_operation_i      ),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .alu_ready_o          (alu_ready_o          ),
    .alu_vinsn_done_o     (alu_vinsn_done_o     ),
    .alu_operand_i        (alu_operand_i        ),
    .alu_operand_valid_i  (alu_operand_valid_i  ),
    .alu_operand_ready_o  (alu_operand_ready_o  ),
    .alu_result_req_o     (alu_result_req_o     ),
    .alu_result_addr_o    (alu_result_addr_o    ),
    .alu_result_wdata_o   (alu_result_wdata_o   ),
    .alu_result_gnt_i     (alu_result_gnt_i     )
  );

  vmul #(
    .VRegWords(VRegWords),
    .vaddr_t  (vaddr_t  )
  ) i_vmul (
    .clk_i                (clk_i                ),
    .reset_i              (reset_i              ),
    .vfu_operation_i      (vfu_operation_i      ),
    .vfu_operation_valid_i(vfu_operation_valid_i),
    .mul_ready_o          (mul_ready_o          ),
    .mul_vinsn_done_o     (mul_vinsn_done_o     ),
    .mul_operand_i        (mul_operand_i        ),
    .mul_operand_valid_i  (mul_operand_valid_i  ),
    .mul_operand_ready_o  (mul_operand_ready_o  ),
    .mul_result_req_o     (mul_result_req_o     ),
    .mul_result_addr_o    (mul_result_addr_o    ),
    .mul_result_wdata_o   (mul_result_wdata_o   ),
    .mul_result_gnt_i     (mul_result_gnt_i     )
  );

endmodule : vector_fus_stage

// File: design/vmul.sv
`timescale 1ns/1ps
/*
  Pipelined vector integer multiplier of one lane, low half of each product.
  Operands are registered first, the product lands in the output register.
  vl must be at least 1 and no more than VRegWords.
*/
module vmul #(
  parameter int unsigned VRegWords = 8,
  parameter type         vaddr_t   = logic
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Operation issue
  input  ara_pkg::vfu_operation_t         vfu_operation_i,
  input  logic                            vfu_operation_valid_i,
  output logic                            mul_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     mul_vinsn_done_o,
  // Operand queues
  input  rvv_pkg::elen_u [1:0]            mul_operand_i,
  input  logic [1:0]                      mul_operand_valid_i,
  output logic [1:0]                      mul_operand_ready_o,
  // Register file write port
  output logic                            mul_result_req_o,
  output vaddr_t                          mul_result_addr_o,
  output rvv_pkg::elen_u                  mul_result_wdata_o,
  input  logic                            mul_result_gnt_i
);
  import ara_pkg::*;
  import rvv_pkg::*;

  typedef struct packed {
    vaddr_t      addr;
    elen_u [1:0] operand;
  } stage_t;

  typedef struct packed {
    vaddr_t addr;
    elen_u  wdata;
  } result_t;

  vfu_operation_t       vinsn_q;
  logic                 active_q;
  logic [VlWidth-1:0]   issue_cnt_q;
  logic [VlWidth-1:0]   commit_cnt_q;
  stage_t               stage_q;
  logic                 stage_valid_q;
  result_t              result_q;
  logic                 result_valid_q;
  logic [NrVInsn-1:0]   done_q;
  logic                 accept;
  logic                 result_ready;
  logic                 stage_ready;
  logic                 take_word;
  logic                 operand_fire;
  logic                 last_gnt;

  // Each assignment is sized to the element, so only the low product bits remain
  function automatic elen_u mul_word(vew_e vew, elen_u a, elen_u b);
    elen_u res;
    res.e64 = '0;
    unique case (vew)
      EW8:     for (int i = 0; i < 8; i++) res.e8[i] = a.e8[i] * b.e8[i];
      EW16:    for (int i = 0; i < 4; i++) res.e16[i] = a.e16[i] * b.e16[i];
      EW32:    for (int i = 0; i < 2; i++) res.e32[i] = a.e32[i] * b.e32[i];
      default: res.e64 = a.e64 * b.e64;
    endcase
    return res;
  endfunction

  assign accept       = vfu_operation_valid_i && !active_q && (vfu_operation_i.op == VMUL);
  // Back-pressure travels from the grant down to the operand ready
  assign result_ready = !result_valid_q || mul_result_gnt_i;
  assign stage_ready  = !stage_valid_q || result_ready;
  assign take_word    = active_q && (issue_cnt_q != vinsn_q.vl) && stage_ready;
  assign operand_fire = take_word && (&mul_operand_valid_i);
  assign last_gnt     = mul_result_gnt_i && (commit_cnt_q == vinsn_q.vl - 1'b1);

  assign mul_ready_o         = !active_q;
  assign mul_operand_ready_o = {2{take_word}};
  assign mul_vinsn_done_o    = done_q;
  assign mul_result_req_o    = result_valid_q;
  assign mul_result_addr_o   = result_q.addr;
  assign mul_result_wdata_o  = result_q.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q       <= 1'b0;
      stage_valid_q  <= 1'b0;
      result_valid_q <= 1'b0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      done_q         <= '0;
    end else begin
      done_q <= '0;
      if (accept) begin
        active_q     <= 1'b1;
        issue_cnt_q  <= '0;
        commit_cnt_q <= '0;
      end
      if (operand_fire) begin
        stage_valid_q <= 1'b1;
        issue_cnt_q   <= issue_cnt_q + 1'b1;
      end else if (result_ready) begin
        stage_valid_q <= 1'b0;
      end
      if (result_ready) result_valid_q <= stage_valid_q;
      if (mul_result_gnt_i) commit_cnt_q <= commit_cnt_q + 1'b1;
      if (last_gnt) begin
        active_q           <= 1'b0;
        done_q[vinsn_q.id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) vinsn_q <= vfu_operation_i;
    if (operand_fire) begin
      stage_q.addr    <= vaddr_t'(vinsn_q.vd * VRegWords + issue_cnt_q);
      stage_q.operand <= mul_operand_i;
    end
    if (result_ready && stage_valid_q) begin
      result_q.addr  <= stage_q.addr;
      result_q.wdata <= mul_word(vinsn_q.vew, stage_q.operand[0], stage_q.operand[1]);
    end
  end

endmodule : vmul

// File: design/valu.sv
`timescale 1ns/1ps
/*
  Vector integer ALU of one lane: add, sub, and, or, xor.
  vl must be at least 1 and no more than VRegWords.
  VMUL operations are ignored here and go to the multiplier.
*/
module valu #(
  parameter int unsigned VRegWords = 8,
  parameter type         vaddr_t   = logic
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // Operation issue
  input  ara_pkg::vfu_operation_t         vfu_operation_i,
  input  logic                            vfu_operation_valid_i,
  output logic                            alu_ready_o,
  output logic [ara_pkg::NrVInsn-1:0]     alu_vinsn_done_o,
  // Operand queues
  input  rvv_pkg::elen_u [1:0]            alu_operand_i,
  input  logic [1:0]                      alu_operand_valid_i,
  output logic [1:0]                      alu_operand_ready_o,
  // Register file write port
  output logic                            alu_result_req_o,
  output vaddr_t                          alu_result_addr_o,
  output rvv_pkg::elen_u                  alu_result_wdata_o,
  input  logic                            alu_result_gnt_i
);
  import ara_pkg::*;
  import rvv_pkg::*;

  typedef struct packed {
    vaddr_t addr;
    elen_u  wdata;
  } result_t;

  vfu_operation_t       vinsn_q;
  logic                 active_q;
  logic [VlWidth-1:0]   issue_cnt_q;
  logic [VlWidth-1:0]   commit_cnt_q;
  result_t              result_q;
  logic                 result_valid_q;
  logic [NrVInsn-1:0]   done_q;
  logic                 accept;
  logic                 take_word;
  logic                 operand_fire;
  logic                 last_gnt;

  // Operation on 64-bit zero extended elements, the caller keeps the low bits
  function automatic logic [63:0] alu_elem(vfu_op_e op, logic [63:0] a, logic [63:0] b);
    unique case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic elen_u alu_word(vfu_op_e op, vew_e vew, elen_u a, elen_u b);
    elen_u res;
    res.e64 = '0;
    unique case (vew)
      EW8:  for (int i = 0; i < 8; i++) res.e8[i] = 8'(alu_elem(op, 64'(a.e8[i]), 64'(b.e8[i])));
      EW16: for (int i = 0; i < 4; i++) res.e16[i] = 16'(alu_elem(op, 64'(a.e16[i]), 64'(b.e16[i])));
      EW32: for (int i = 0; i < 2; i++) res.e32[i] = 32'(alu_elem(op, 64'(a.e32[i]), 64'(b.e32[i])));
      default: res.e64 = alu_elem(op, a.e64, b.e64);
    endcase
    return res;
  endfunction

  assign accept       = vfu_operation_valid_i && !active_q && (vfu_operation_i.op != VMUL);
  // A word is taken only if the result register is free or drains this cycle
  assign take_word    = active_q && (issue_cnt_q != vinsn_q.vl) &&
                        (!result_valid_q || alu_result_gnt_i);
  assign operand_fire = take_word && (&alu_operand_valid_i);
  assign last_gnt     = alu_result_gnt_i && (commit_cnt_q == vinsn_q.vl - 1'b1);

  assign alu_ready_o         = !active_q;
  assign alu_operand_ready_o = {2{take_word}};
  assign alu_vinsn_done_o    = done_q;
  assign alu_result_req_o    = result_valid_q;
  assign alu_result_addr_o   = result_q.addr;
  assign alu_result_wdata_o  = result_q.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q       <= 1'b0;
      result_valid_q <= 1'b0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      done_q         <= '0;
    end else begin
      done_q <= '0;
      if (accept) begin
        active_q     <= 1'b1;
        issue_cnt_q  <= '0;
        commit_cnt_q <= '0;
      end
      if (operand_fire) begin
        result_valid_q <= 1'b1;
        issue_cnt_q    <= issue_cnt_q + 1'b1;
      end else if (alu_result_gnt_i) begin
        result_valid_q <= 1'b0;
      end
      if (alu_result_gnt_i) commit_cnt_q <= commit_cnt_q + 1'b1;
      // Done pulse and ready return together, one cycle after the last grant
      if (last_gnt) begin
        active_q            <= 1'b0;
        done_q[vinsn_q.id]  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) vinsn_q <= vfu_operation_i;
    if (operand_fire) begin
      result_q.addr  <= vaddr_t'(vinsn_q.vd * VRegWords + issue_cnt_q);
      result_q.wdata <= alu_word(vinsn_q.op, vinsn_q.vew, alu_operand_i[0], alu_operand_i[1]);
    end
  end

endmodule : valu

// File: design/ara_pkg.sv
/*
  Lane level definitions shared by the functional units.
  An operation carries its own word count, so vl is per lane and not per vector.
*/
package ara_pkg;

  // Instruction ids in flight, one done bit each
  localparam int unsigned NrVInsn = 8;

  // Width of the per-lane word count
  localparam int unsigned VlWidth = 6;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Operations understood by the lane's functional units
  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VMUL = 3'd5
  } vfu_op_e;

  // One vector operation as broadcast to the units
  typedef struct packed {
    vfu_op_e             op;
    rvv_pkg::vew_e       vew;
    logic [VlWidth-1:0]  vl;
    logic [4:0]          vd;
    vid_t                id;
  } vfu_operation_t;

endpackage : ara_pkg

// File: design/rvv_pkg.sv
/*
  Element level definitions of the vector extension.
  Elements are packed into one 64-bit word, element 0 in the low bits.
*/
package rvv_pkg;

  // Widest element, also the lane datapath width
  localparam int unsigned ELEN = 64;

  // Element width of an operation
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // One lane word, seen at each of the four element widths
  typedef union packed {
    logic [ELEN-1:0]                 e64;
    logic [ELEN/32-1:0][31:0]        e32;
    logic [ELEN/16-1:0][15:0]        e16;
    logic [ELEN/8-1:0][7:0]          e8;
  } elen_u;

endpackage : rvv_pkg
